// ==== source/ram_pkg.sv ====
package ram_pkg;

    // ------------------------------------------------------------------
    // Memory geometry
    // ------------------------------------------------------------------
    localparam int ADDR_WIDTH = 12;    // 4K words.
    localparam int DATA_WIDTH = 8;

    // ------------------------------------------------------------------
    // Pattern rule
    // ------------------------------------------------------------------
    localparam int PATTERN_WIDTH = 32; // Widest word the rule supports.

    typedef logic [PATTERN_WIDTH-1:0] pattern_arg_t;

    // Word at a given offset into a region is base plus offset, kept to width bits.
    function automatic pattern_arg_t pattern_word(
        input pattern_arg_t base,
        input pattern_arg_t offset,
        input int           width
    );
        pattern_arg_t sum;
        pattern_arg_t mask;
        sum  = base + offset;
        mask = (width >= PATTERN_WIDTH) ? '1 : ((pattern_arg_t'(1) << width) - 1'b1);
        return sum & mask;
    endfunction

endpackage

// ==== source/seq_pkg.sv ====
package seq_pkg;

    // ------------------------------------------------------------------
    // Job operations
    // ------------------------------------------------------------------
    typedef enum logic [1:0] {
        OP_WRITE_VERIFY = 2'd0,
        OP_WRITE_ONLY   = 2'd1,
        OP_VERIFY_ONLY  = 2'd2  // Code 3 behaves the same.
    } op_t;

    function automatic logic op_has_write(input op_t op);
        return (op == OP_WRITE_VERIFY) || (op == OP_WRITE_ONLY);
    endfunction

    function automatic logic op_has_read(input op_t op);
        return op != OP_WRITE_ONLY;
    endfunction

    // ------------------------------------------------------------------
    // Sequencer states
    // ------------------------------------------------------------------
    typedef enum logic [2:0] {
        S_IDLE  = 3'd0,
        S_WRITE = 3'd1,
        S_READ  = 3'd2,
        S_DONE  = 3'd3
    } seq_state_t;

endpackage

// ==== source/job_if.sv ====
interface job_if #(
    parameter int ADDR_WIDTH = ram_pkg::ADDR_WIDTH,
    parameter int DATA_WIDTH = ram_pkg::DATA_WIDTH
);
    logic                  fs;        // Start pulse.
    logic                  fd;        // Finish pulse.
    logic [ADDR_WIDTH-1:0] addr_init; // First word of the region.
    logic [ADDR_WIDTH:0]   data_len;  // Word count up to a full memory.
    logic [DATA_WIDTH-1:0] base;      // Pattern base.

    modport sequencer (
        output fs,
        output addr_init,
        output data_len,
        output base,
        input  fd
    );

    modport worker (
        input  fs,
        input  addr_init,
        input  data_len,
        input  base,
        output fd
    );

endinterface

// ==== source/dual_port_ram.sv ====
module dual_port_ram #(
    parameter int ADDR_WIDTH = ram_pkg::ADDR_WIDTH,
    parameter int DATA_WIDTH = ram_pkg::DATA_WIDTH
) (
    input  logic                  clk,

    input  logic [ADDR_WIDTH-1:0] wr_addr,
    input  logic [DATA_WIDTH-1:0] wr_data,
    input  logic                  wr_en,

    input  logic [ADDR_WIDTH-1:0] rd_addr,
    output logic [DATA_WIDTH-1:0] rd_data
);
    localparam int DEPTH = 2 ** ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // ------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // ------------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------------
    // Registered read; a same-cycle write is seen one access later.
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== source/ram_writer.sv ====
module ram_writer #(
    parameter int ADDR_WIDTH = ram_pkg::ADDR_WIDTH,
    parameter int DATA_WIDTH = ram_pkg::DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst,

    job_if.worker                 job,

    output logic [ADDR_WIDTH-1:0] wr_addr,
    output logic [DATA_WIDTH-1:0] wr_data,
    output logic                  wr_en
);
    logic [ADDR_WIDTH:0] offset;
    logic                last_word;

    assign last_word = (offset == job.data_len - 1'b1);

    // ------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_en  <= 1'b0;
            job.fd <= 1'b0;
        end else begin
            job.fd <= 1'b0;
            if (job.fs) begin
                wr_en  <= (job.data_len != '0);
                job.fd <= (job.data_len == '0); // Empty job finishes at once.
            end else if (wr_en && last_word) begin
                wr_en  <= 1'b0;
                job.fd <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // Address and offset
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (job.fs) begin
            wr_addr <= job.addr_init;
            offset  <= '0;
        end else if (wr_en) begin
            wr_addr <= wr_addr + 1'b1; // Wraps at the top of memory.
            offset  <= offset + 1'b1;
        end
    end

    assign wr_data = DATA_WIDTH'(ram_pkg::pattern_word(
        ram_pkg::pattern_arg_t'(job.base),
        ram_pkg::pattern_arg_t'(offset),
        DATA_WIDTH
    ));

endmodule

// ==== source/ram_reader.sv ====
module ram_reader #(
    parameter int ADDR_WIDTH = ram_pkg::ADDR_WIDTH,
    parameter int DATA_WIDTH = ram_pkg::DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst,

    job_if.worker                 job,

    output logic [ADDR_WIDTH-1:0] rd_addr,
    input  logic [DATA_WIDTH-1:0] rd_data,
    output logic [ADDR_WIDTH:0]   err_count
);
    logic                  issue_valid; // An address is on rd_addr.
    logic [ADDR_WIDTH:0]   offset;
    logic                  last_addr;
    logic [DATA_WIDTH-1:0] exp_now;

    logic                  cmp_valid;   // rd_data is being compared.
    logic                  cmp_last;
    logic [DATA_WIDTH-1:0] exp_word;

    assign last_addr = (offset == job.data_len - 1'b1);

    assign exp_now = DATA_WIDTH'(ram_pkg::pattern_word(
        ram_pkg::pattern_arg_t'(job.base),
        ram_pkg::pattern_arg_t'(offset),
        DATA_WIDTH
    ));

    // ------------------------------------------------------------------
    // Control and error count
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issue_valid <= 1'b0;
            cmp_valid   <= 1'b0;
            cmp_last    <= 1'b0;
            job.fd      <= 1'b0;
            err_count   <= '0;
        end else begin
            cmp_valid <= issue_valid;
            cmp_last  <= issue_valid && last_addr;
            job.fd    <= (job.fs && job.data_len == '0) || (cmp_valid && cmp_last);

            if (job.fs) begin
                issue_valid <= (job.data_len != '0);
            end else if (issue_valid && last_addr) begin
                issue_valid <= 1'b0;
            end

            if (job.fs) begin
                err_count <= '0;
            end else if (cmp_valid && rd_data != exp_word) begin
                err_count <= err_count + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // Address issue and expected-word delay
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (job.fs) begin
            rd_addr <= job.addr_init;
            offset  <= '0;
        end else if (issue_valid) begin
            rd_addr <= rd_addr + 1'b1;
            offset  <= offset + 1'b1;
        end
        exp_word <= exp_now; // Lines up with the RAM read latency.
    end

endmodule

// ==== source/test_sequencer.sv ====
module test_sequencer #(
    parameter int ADDR_WIDTH = ram_pkg::ADDR_WIDTH,
    parameter int DATA_WIDTH = ram_pkg::DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  start,
    input  seq_pkg::op_t          op,
    input  logic [ADDR_WIDTH-1:0] addr_init,
    input  logic [ADDR_WIDTH:0]   data_len,
    input  logic [DATA_WIDTH-1:0] base,
    output logic                  busy,
    output logic                  done,

    job_if.sequencer              wr_job,
    job_if.sequencer              rd_job
);
    seq_pkg::seq_state_t   state, next_state;
    seq_pkg::op_t          op_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [ADDR_WIDTH:0]   len_q;
    logic [ADDR_WIDTH:0]   rd_len_q;
    logic [DATA_WIDTH-1:0] base_q;
    logic                  accept;

    assign busy   = (state == seq_pkg::S_WRITE) || (state == seq_pkg::S_READ);
    assign done   = (state == seq_pkg::S_DONE);
    assign accept = start && !busy;

    // ------------------------------------------------------------------
    // State machine
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) state <= seq_pkg::S_IDLE;
        else     state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            seq_pkg::S_IDLE, seq_pkg::S_DONE: begin
                next_state = seq_pkg::S_IDLE;
                if (accept) begin
                    next_state = seq_pkg::op_has_write(op) ? seq_pkg::S_WRITE
                                                           : seq_pkg::S_READ;
                end
            end
            seq_pkg::S_WRITE: begin
                if (wr_job.fd) begin
                    next_state = seq_pkg::op_has_read(op_q) ? seq_pkg::S_READ
                                                            : seq_pkg::S_DONE;
                end
            end
            seq_pkg::S_READ: begin
                if (rd_job.fd) next_state = seq_pkg::S_DONE;
            end
            default: next_state = seq_pkg::S_IDLE;
        endcase
    end

    // ------------------------------------------------------------------
    // Stage start pulses
    // ------------------------------------------------------------------
    // A write-only job also starts an empty reader pass, which clears the count.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_job.fs <= 1'b0;
            rd_job.fs <= 1'b0;
        end else begin
            wr_job.fs <= accept && seq_pkg::op_has_write(op);
            rd_job.fs <= (accept && !(seq_pkg::op_has_write(op) && seq_pkg::op_has_read(op)))
                      || (state == seq_pkg::S_WRITE && wr_job.fd && seq_pkg::op_has_read(op_q));
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q     <= op;
            addr_q   <= addr_init;
            len_q    <= data_len;
            rd_len_q <= seq_pkg::op_has_read(op) ? data_len : '0;
            base_q   <= base;
        end
    end

    assign wr_job.addr_init = addr_q;
    assign wr_job.data_len  = len_q;
    assign wr_job.base      = base_q;

    assign rd_job.addr_init = addr_q;
    assign rd_job.data_len  = rd_len_q;
    assign rd_job.base      = base_q;

endmodule

// ==== source/mem_test_top.sv ====
module mem_test_top #(
    parameter int ADDR_WIDTH = ram_pkg::ADDR_WIDTH,
    parameter int DATA_WIDTH = ram_pkg::DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  start,
    input  seq_pkg::op_t          op,
    input  logic [ADDR_WIDTH-1:0] addr_init,
    input  logic [ADDR_WIDTH:0]   data_len,
    input  logic [DATA_WIDTH-1:0] base,

    output logic                  busy,
    output logic                  done,
    output logic [ADDR_WIDTH:0]   err_count
);
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [DATA_WIDTH-1:0] wr_data;
    logic                  wr_en;
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic [DATA_WIDTH-1:0] rd_data;

    job_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) wr_job ();
    job_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) rd_job ();

    test_sequencer #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) seq0 (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .op        (op),
        .addr_init (addr_init),
        .data_len  (data_len),
        .base      (base),
        .busy      (busy),
        .done      (done),
        .wr_job    (wr_job.sequencer),
        .rd_job    (rd_job.sequencer)
    );

    ram_writer #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) writer0 (
        .clk     (clk),
        .rst     (rst),
        .job     (wr_job.worker),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_en   (wr_en)
    );

    dual_port_ram #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) ram0 (
        .clk     (clk),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_en   (wr_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    ram_reader #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) reader0 (
        .clk       (clk),
        .rst       (rst),
        .job       (rd_job.worker),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .err_count (err_count)
    );

endmodule

// ==== bench/mem_test_tb.sv ====
module mem_test_tb;

    localparam int AW      = ram_pkg::ADDR_WIDTH;
    localparam int DW      = ram_pkg::DATA_WIDTH;
    localparam int LW      = AW + 1;
    localparam int DEPTH   = 1 << AW;
    localparam int TIMEOUT = 4 * DEPTH + 100; // Enough cycles for a full-memory write-verify.

    logic          clk;
    logic          rst;
    logic          start;
    seq_pkg::op_t  op;
    logic [AW-1:0] addr_init;
    logic [LW-1:0] data_len;
    logic [DW-1:0] base;
    logic          busy;
    logic          done;
    logic [LW-1:0] err_count;

    logic [DW-1:0] model [DEPTH]; // Expected RAM contents.

    mem_test_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .op        (op),
        .addr_init (addr_init),
        .data_len  (data_len),
        .base      (base),
        .busy      (busy),
        .done      (done),
        .err_count (err_count)
    );

    always #10 clk = ~clk;

    // ----------------------------------------------------------------------
    // Checking and model helpers
    // ----------------------------------------------------------------------
    task automatic abort_run();
        $display("Test failures found");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    // Word i of a region holds base plus i, truncated to the word width.
    task automatic model_write(input logic [AW-1:0] a, input int len, input logic [DW-1:0] b);
        for (int i = 0; i < len; i++) begin
            model[a + AW'(i)] = b + DW'(i);
        end
    endtask

    function automatic int expected_errors(input logic [AW-1:0] a, input int len,
                                           input logic [DW-1:0] b);
        int count;
        count = 0;
        for (int i = 0; i < len; i++) begin
            if (model[a + AW'(i)] !== b + DW'(i)) count++;
        end
        return count;
    endfunction

    // ----------------------------------------------------------------------
    // Job driving
    // ----------------------------------------------------------------------
    task automatic start_job(input seq_pkg::op_t o, input logic [AW-1:0] a, input int len,
                             input logic [DW-1:0] b);
        @(posedge clk);
        start     <= 1'b1;
        op        <= o;
        addr_init <= a;
        data_len  <= LW'(len);
        base      <= b;
        @(posedge clk);
        start     <= 1'b0;
    endtask

    task automatic wait_done(input string name, output int count);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!done) begin
            cycles++;
            assert (cycles < TIMEOUT) else begin
                $display("%s: done never came within %0d cycles", name, TIMEOUT);
                abort_run();
            end
            @(negedge clk);
        end
        count = int'(err_count);
    endtask

    task automatic run_job(input string name, input seq_pkg::op_t o, input logic [AW-1:0] a,
                           input int len, input logic [DW-1:0] b, input int expected);
        int count;
        start_job(o, a, len, b);
        wait_done(name, count);
        check_value(name, expected, count);
        if (o == seq_pkg::OP_WRITE_VERIFY || o == seq_pkg::OP_WRITE_ONLY) begin
            model_write(a, len, b);
        end
    endtask

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------
    task automatic test_reset_idle();
        logic [AW-1:0] a;
        logic [DW-1:0] b;
        int            len;
        @(negedge clk);
        check_value("reset_idle busy", 0, int'(busy));
        check_value("reset_idle done", 0, int'(done));
        a   = AW'($urandom);
        b   = DW'($urandom);
        len = 1 + int'($urandom_range(199, 0));
        run_job("reset_idle write_verify", seq_pkg::OP_WRITE_VERIFY, a, len, b, 0);
    endtask

    task automatic test_write_then_verify();
        logic [AW-1:0] a;
        logic [DW-1:0] b;
        logic [DW-1:0] delta;
        int            len;
        a     = AW'($urandom);
        b     = DW'($urandom);
        delta = DW'(1 + $urandom_range(254, 0)); // Nonzero so every word differs.
        len   = 1 + int'($urandom_range(127, 0));
        run_job("wo_vo write_only", seq_pkg::OP_WRITE_ONLY, a, len, b, 0);
        run_job("wo_vo verify_same", seq_pkg::OP_VERIFY_ONLY, a, len, b, 0);
        run_job("wo_vo verify_other", seq_pkg::OP_VERIFY_ONLY, a, len, b + delta, len);
    endtask

    task automatic test_overlap();
        logic [AW-1:0] a1;
        logic [AW-1:0] a2;
        logic [DW-1:0] b1;
        logic [DW-1:0] b2;
        int            len;
        a1  = AW'($urandom);
        len = 32 + int'($urandom_range(63, 0));
        a2  = a1 + AW'(len / 2); // Second half of A is rewritten.
        b1  = DW'($urandom);
        // A b2 of b1 plus len/2 would rewrite the overlap with the same words.
        do begin
            b2 = DW'($urandom);
        end while (b2 == b1 || b2 == b1 + DW'(len / 2));
        run_job("overlap write_a", seq_pkg::OP_WRITE_ONLY, a1, len, b1, 0);
        run_job("overlap write_b", seq_pkg::OP_WRITE_ONLY, a2, len, b2, 0);
        run_job("overlap verify_a", seq_pkg::OP_VERIFY_ONLY, a1, len, b1,
                expected_errors(a1, len, b1));
    endtask

    task automatic test_wrap_and_zero();
        logic [AW-1:0] a;
        logic [DW-1:0] b;
        a = AW'(DEPTH - 10);
        b = DW'($urandom);
        run_job("wrap write_verify", seq_pkg::OP_WRITE_VERIFY, a, 25, b, 0);
        // Words 10 to 24 landed at the bottom of memory.
        run_job("wrap verify_low", seq_pkg::OP_VERIFY_ONLY, AW'(0), 15, b + DW'(10),
                expected_errors(AW'(0), 15, b + DW'(10)));
        run_job("zero write_only", seq_pkg::OP_WRITE_ONLY, a, 0, b + DW'(1), 0);
        run_job("zero write_verify", seq_pkg::OP_WRITE_VERIFY, a, 0, b + DW'(2), 0);
        run_job("zero verify_only", seq_pkg::OP_VERIFY_ONLY, a, 0, b + DW'(3), 0);
        run_job("zero region_intact", seq_pkg::OP_VERIFY_ONLY, a, 25, b,
                expected_errors(a, 25, b));
    endtask

    task automatic test_start_while_busy();
        logic [AW-1:0] a;
        logic [DW-1:0] b;
        int            len;
        int            count;
        int            extra;
        a     = AW'($urandom);
        b     = DW'($urandom);
        len   = 40 + int'($urandom_range(39, 0));
        extra = 0;
        start_job(seq_pkg::OP_WRITE_VERIFY, a, len, b);
        @(negedge clk);
        check_value("busy_start busy", 1, int'(busy));
        // Would corrupt the region if it were accepted.
        start_job(seq_pkg::OP_WRITE_ONLY, a, len, b + DW'(1));
        wait_done("busy_start first_job", count);
        check_value("busy_start err_count", 0, count);
        model_write(a, len, b);
        for (int i = 0; i < 3 * len; i++) begin
            @(negedge clk);
            if (done) extra++;
        end
        check_value("busy_start extra_done", 0, extra);
        run_job("busy_start region_intact", seq_pkg::OP_VERIFY_ONLY, a, len, b,
                expected_errors(a, len, b));
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        void'($urandom(32'h4f25));
        clk        = 1'b0;
        rst        = 1'b1;
        start      = 1'b0;
        op         = seq_pkg::OP_WRITE_VERIFY;
        addr_init  = '0;
        data_len   = '0;
        base       = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        test_reset_idle();
        test_write_then_verify();
        test_overlap();
        test_wrap_and_zero();
        test_start_while_busy();

        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== compile.f ====
source/ram_pkg.sv
source/seq_pkg.sv
source/job_if.sv
source/dual_port_ram.sv
source/ram_writer.sv
source/ram_reader.sv
source/test_sequencer.sv
source/mem_test_top.sv
bench/mem_test_tb.sv

// ==== Makefile ====
TOP := mem_test_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir -o sim
	./obj_dir/sim

clean:
	rm -rf obj_dir
